/* core_pkg.sv */
package core_pkg;

   localparam int xlen = 32;

   typedef logic [4:0] reg_addr_t;

   // major opcodes, bits [6:0] of the instruction
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_pass_b // lui, immediate straight through
   } alu_op_t;

   typedef enum logic [1:0] {
      wb_alu,
      wb_load,
      wb_pc_plus4 // jal link
   } wb_sel_t;

   typedef enum logic {
      size_byte,
      size_word
   } mem_size_t;

endpackage

/* fetch_stage.sv */
module fetch_stage #(
   parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        stall_i,
   input  logic        redirect_i,
   input  logic [31:2] redirect_target_i,
   output logic [31:2] instr_addr_o,
   input  logic [31:0] instr_data_i,
   output logic [31:0] instr_o,
   output logic [31:2] pc_o,
   output logic        valid_o
);

   logic [31:2] pc_q; // word address being fetched

   assign instr_addr_o = pc_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc_q <= reset_pc[31:2];
      end else if (redirect_i) begin
         pc_q <= redirect_target_i; // taken branch or jal from execute
      end else if (!stall_i) begin
         pc_q <= pc_q + 30'd1;
      end
   end

   // IF/ID register
   always_ff @(posedge clk_i) begin
      if (reset_i || redirect_i) begin
         valid_o <= 1'b0; // younger instruction squashed
      end else if (!stall_i) begin
         valid_o <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!stall_i) begin
         instr_o <= instr_data_i;
         pc_o    <= pc_q;
      end
   end

endmodule

/* decode_stage.sv */
module decode_stage (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [31:0]               instr_i,
   input  logic [31:2]               pc_i,
   input  logic                      valid_i,
   input  logic                      flush_i,
   input  core_pkg::reg_addr_t       ex_rd_i,
   input  logic                      ex_is_load_i,
   output core_pkg::reg_addr_t       rs1_addr_o,
   output core_pkg::reg_addr_t       rs2_addr_o,
   input  logic [core_pkg::xlen-1:0] rs1_data_i,
   input  logic [core_pkg::xlen-1:0] rs2_data_i,
   output logic                      stall_o,
   output logic [core_pkg::xlen-1:0] rs1_val_o,
   output logic [core_pkg::xlen-1:0] rs2_val_o,
   output logic [core_pkg::xlen-1:0] imm_o,
   output core_pkg::reg_addr_t       rs1_o,
   output core_pkg::reg_addr_t       rs2_o,
   output core_pkg::alu_op_t         alu_op_o,
   output logic                      alu_src_imm_o,
   output core_pkg::wb_sel_t         wb_sel_o,
   output core_pkg::mem_size_t       mem_size_o,
   output logic                      load_o,
   output logic                      store_o,
   output logic                      branch_o,
   output logic                      branch_ne_o,
   output logic                      jump_o,
   output logic [31:2]               pc_o,
   output core_pkg::reg_addr_t       rd_o
);
   import core_pkg::*;

   logic [6:0]      opcode;
   logic [2:0]      f3;
   reg_addr_t       rd;
   logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

   // decoded control, zero means bubble
   alu_op_t         d_alu_op;
   logic            d_src_imm;
   wb_sel_t         d_wb_sel;
   mem_size_t       d_size;
   logic            d_load, d_store, d_branch, d_bne, d_jump;
   reg_addr_t       d_rd; // left at x0 when nothing is written back
   logic [xlen-1:0] d_imm;
   logic            use_rs1, use_rs2;

   assign opcode     = instr_i[6:0];
   assign f3         = instr_i[14:12];
   assign rd         = instr_i[11:7];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};

   always_comb begin
      d_alu_op  = alu_add;
      d_src_imm = 1'b0;
      d_wb_sel  = wb_alu;
      d_size    = size_word;
      d_load    = 1'b0;
      d_store   = 1'b0;
      d_branch  = 1'b0;
      d_bne     = 1'b0;
      d_jump    = 1'b0;
      d_rd      = '0;
      d_imm     = '0;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
      if (valid_i) begin
         case (opcode)
            op_lui: begin
               d_alu_op  = alu_pass_b;
               d_src_imm = 1'b1;
               d_imm     = imm_u;
               d_rd      = rd;
            end
            op_jal: begin
               d_jump   = 1'b1;
               d_wb_sel = wb_pc_plus4;
               d_imm    = imm_j;
               d_rd     = rd;
            end
            op_branch: begin
               if (f3[2:1] == 2'b00) begin // beq, bne
                  d_branch = 1'b1;
                  d_bne    = f3[0];
                  d_imm    = imm_b;
                  use_rs1  = 1'b1;
                  use_rs2  = 1'b1;
               end
            end
            op_load: begin
               if (f3 == 3'b010 || f3 == 3'b100) begin // lw, lbu
                  d_load    = 1'b1;
                  d_size    = f3[2] ? size_byte : size_word;
                  d_wb_sel  = wb_load;
                  d_src_imm = 1'b1;
                  d_imm     = imm_i;
                  d_rd      = rd;
                  use_rs1   = 1'b1;
               end
            end
            op_store: begin
               if (f3 == 3'b000 || f3 == 3'b010) begin // sb, sw
                  d_store   = 1'b1;
                  d_size    = f3[1] ? size_word : size_byte;
                  d_src_imm = 1'b1;
                  d_imm     = imm_s;
                  use_rs1   = 1'b1;
                  use_rs2   = 1'b1;
               end
            end
            op_imm: begin
               d_src_imm = 1'b1;
               d_imm     = imm_i;
               d_rd      = rd;
               use_rs1   = 1'b1;
               case (f3)
                  3'b000:  d_alu_op = alu_add;
                  3'b100:  d_alu_op = alu_xor;
                  3'b110:  d_alu_op = alu_or;
                  3'b111:  d_alu_op = alu_and;
                  default: d_rd = '0; // unsupported, no write
               endcase
            end
            op_reg: begin
               d_rd    = rd;
               use_rs1 = 1'b1;
               use_rs2 = 1'b1;
               case (f3)
                  3'b000:  d_alu_op = instr_i[30] ? alu_sub : alu_add;
                  3'b010:  d_alu_op = alu_slt;
                  3'b100:  d_alu_op = alu_xor;
                  3'b110:  d_alu_op = alu_or;
                  3'b111:  d_alu_op = alu_and;
                  default: d_rd = '0;
               endcase
            end
            default: ; // anything else is a bubble
         endcase
      end
   end

   // load in execute feeding this instruction, hold one cycle
   assign stall_o = ex_is_load_i && ex_rd_i != '0 &&
                    ((use_rs1 && rs1_addr_o == ex_rd_i) ||
                     (use_rs2 && rs2_addr_o == ex_rd_i));

   // ID/EX register, control part
   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i || stall_o) begin
         load_o   <= 1'b0;
         store_o  <= 1'b0;
         branch_o <= 1'b0;
         jump_o   <= 1'b0;
         rd_o     <= '0;
      end else begin
         load_o   <= d_load;
         store_o  <= d_store;
         branch_o <= d_branch;
         jump_o   <= d_jump;
         rd_o     <= d_rd;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk_i) begin
      rs1_val_o     <= rs1_data_i;
      rs2_val_o     <= rs2_data_i;
      imm_o         <= d_imm;
      rs1_o         <= rs1_addr_o;
      rs2_o         <= rs2_addr_o;
      alu_op_o      <= d_alu_op;
      alu_src_imm_o <= d_src_imm;
      wb_sel_o      <= d_wb_sel;
      mem_size_o    <= d_size;
      branch_ne_o   <= d_bne;
      pc_o          <= pc_i;
   end

endmodule

/* register_file.sv */
module register_file (
   input  logic                      clk_i,
   input  core_pkg::reg_addr_t       rs1_addr_i,
   input  core_pkg::reg_addr_t       rs2_addr_i,
   output logic [core_pkg::xlen-1:0] rs1_data_o,
   output logic [core_pkg::xlen-1:0] rs2_data_o,
   input  logic                      we_i,
   input  core_pkg::reg_addr_t       rd_i,
   input  logic [core_pkg::xlen-1:0] wd_i
);
   import core_pkg::*;

   logic [xlen-1:0] regs [32];

   always_ff @(posedge clk_i) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wd_i;
      end
   end

   // x0 reads zero, a write in the same cycle passes straight through
   assign rs1_data_o = (rs1_addr_i == '0)                  ? '0   :
                       (we_i && rd_i == rs1_addr_i)        ? wd_i : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0)                  ? '0   :
                       (we_i && rd_i == rs2_addr_i)        ? wd_i : regs[rs2_addr_i];

endmodule

/* execute_stage.sv */
module execute_stage (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [core_pkg::xlen-1:0] rs1_val_i,
   input  logic [core_pkg::xlen-1:0] rs2_val_i,
   input  logic [core_pkg::xlen-1:0] imm_i,
   input  core_pkg::reg_addr_t       rs1_i,
   input  core_pkg::reg_addr_t       rs2_i,
   input  core_pkg::alu_op_t         alu_op_i,
   input  logic                      alu_src_imm_i,
   input  core_pkg::wb_sel_t         wb_sel_i,
   input  core_pkg::mem_size_t       mem_size_i,
   input  logic                      load_i,
   input  logic                      store_i,
   input  logic                      branch_i,
   input  logic                      branch_ne_i,
   input  logic                      jump_i,
   input  logic [31:2]               pc_i,
   input  core_pkg::reg_addr_t       rd_i,
   input  core_pkg::reg_addr_t       mem_rd_i,
   input  logic                      mem_we_i,
   input  logic [core_pkg::xlen-1:0] mem_wd_i,
   output logic                      redirect_o,
   output logic [31:2]               redirect_target_o,
   output logic [core_pkg::xlen-1:0] alu_result_o,
   output logic [core_pkg::xlen-1:0] store_data_o,
   output core_pkg::reg_addr_t       rd_o,
   output logic                      we_o,
   output core_pkg::wb_sel_t         wb_sel_o,
   output core_pkg::mem_size_t       mem_size_o,
   output logic                      load_o,
   output logic                      store_o,
   output logic [31:2]               pc_o
);
   import core_pkg::*;

   logic [xlen-1:0] ex_fwd_val;
   logic [xlen-1:0] fwd_a, fwd_b;
   logic [xlen-1:0] op_b;
   logic [xlen-1:0] result;
   logic            equal;

   // value held in EX/MEM, a jal there carries its link
   assign ex_fwd_val = (wb_sel_o == wb_pc_plus4) ? {pc_o + 30'd1, 2'b00} : alu_result_o;

   // we_o and mem_we_i are only set for a nonzero rd, so x0 never forwards
   assign fwd_a = (we_o && !load_o && rd_o == rs1_i) ? ex_fwd_val :
                  (mem_we_i && mem_rd_i == rs1_i)     ? mem_wd_i   : rs1_val_i;
   assign fwd_b = (we_o && !load_o && rd_o == rs2_i) ? ex_fwd_val :
                  (mem_we_i && mem_rd_i == rs2_i)     ? mem_wd_i   : rs2_val_i;

   assign op_b = alu_src_imm_i ? imm_i : fwd_b;

   always_comb begin
      case (alu_op_i)
         alu_sub:    result = fwd_a - op_b;
         alu_and:    result = fwd_a & op_b;
         alu_or:     result = fwd_a | op_b;
         alu_xor:    result = fwd_a ^ op_b;
         alu_slt:    result = {{(xlen-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
         alu_pass_b: result = op_b;
         default:    result = fwd_a + op_b;
      endcase
   end

   assign equal             = (fwd_a == fwd_b);
   assign redirect_o        = jump_i || (branch_i && (equal ^ branch_ne_i));
   assign redirect_target_o = pc_i + imm_i[31:2]; // word-aligned targets only

   // EX/MEM register, control part
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         we_o    <= 1'b0;
         load_o  <= 1'b0;
         store_o <= 1'b0;
      end else begin
         we_o    <= (rd_i != '0);
         load_o  <= load_i;
         store_o <= store_i;
      end
   end

   always_ff @(posedge clk_i) begin
      alu_result_o <= result;
      store_data_o <= fwd_b;
      rd_o         <= rd_i;
      wb_sel_o     <= wb_sel_i;
      mem_size_o   <= mem_size_i;
      pc_o         <= pc_i;
   end

endmodule

/* memory_stage.sv */
module memory_stage (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [core_pkg::xlen-1:0] alu_result_i,
   input  logic [core_pkg::xlen-1:0] store_data_i,
   input  core_pkg::reg_addr_t       rd_i,
   input  logic                      we_i,
   input  core_pkg::wb_sel_t         wb_sel_i,
   input  core_pkg::mem_size_t       mem_size_i,
   input  logic                      load_i,
   input  logic                      store_i,
   input  logic [31:2]               pc_i,
   output logic [31:2]               data_addr_o,
   output logic [core_pkg::xlen-1:0] data_wdata_o,
   output logic [3:0]                data_be_o,
   output logic                      data_we_o,
   output logic                      data_re_o,
   input  logic [core_pkg::xlen-1:0] data_rdata_i,
   output core_pkg::reg_addr_t       wb_rd_o,
   output logic                      wb_we_o,
   output logic [core_pkg::xlen-1:0] wb_data_o
);
   import core_pkg::*;

   logic            is_byte;
   logic [xlen-1:0] lane;
   logic [xlen-1:0] load_val;
   logic [xlen-1:0] wb_val;

   assign is_byte = (mem_size_i == size_byte);

   assign data_addr_o  = alu_result_i[31:2];
   assign data_wdata_o = is_byte ? {4{store_data_i[7:0]}} : store_data_i; // sb on every lane
   assign data_be_o    = !store_i ? 4'b0000 :
                         is_byte  ? 4'b0001 << alu_result_i[1:0] : 4'b1111;
   assign data_we_o    = store_i;
   assign data_re_o    = load_i;

   // addressed byte moved down to lane 0 for lbu
   assign lane     = data_rdata_i >> {alu_result_i[1:0], 3'b000};
   assign load_val = is_byte ? {{(xlen-8){1'b0}}, lane[7:0]} : data_rdata_i;

   always_comb begin
      case (wb_sel_i)
         wb_load:     wb_val = load_val;
         wb_pc_plus4: wb_val = {pc_i + 30'd1, 2'b00};
         default:     wb_val = alu_result_i;
      endcase
   end

   // MEM/WB register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wb_we_o <= 1'b0;
      end else begin
         wb_we_o <= we_i;
      end
   end

   always_ff @(posedge clk_i) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= wb_val;
   end

endmodule

/* core.sv */
module core #(
   parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   output logic [31:2]               instr_addr_o,
   input  logic [31:0]               instr_data_i,
   output logic [31:2]               data_addr_o,
   output logic [core_pkg::xlen-1:0] data_wdata_o,
   output logic [3:0]                data_be_o,
   output logic                      data_we_o,
   output logic                      data_re_o,
   input  logic [core_pkg::xlen-1:0] data_rdata_i
);
   import core_pkg::*;

   // fetch to decode
   logic [31:0] if_instr;
   logic [31:2] if_pc;
   logic        if_valid;
   logic        stall;
   logic        redirect;
   logic [31:2] redirect_target;

   // register file read side
   reg_addr_t       rs1_addr, rs2_addr;
   logic [xlen-1:0] rs1_data, rs2_data;

   // ID/EX
   logic [xlen-1:0] id_rs1_val, id_rs2_val, id_imm;
   reg_addr_t       id_rs1, id_rs2, id_rd;
   alu_op_t         id_alu_op;
   logic            id_src_imm;
   wb_sel_t         id_wb_sel;
   mem_size_t       id_size;
   logic            id_load, id_store, id_branch, id_bne, id_jump;
   logic [31:2]     id_pc;

   // EX/MEM
   logic [xlen-1:0] ex_alu_result, ex_store_data;
   reg_addr_t       ex_rd;
   logic            ex_we, ex_load, ex_store;
   wb_sel_t         ex_wb_sel;
   mem_size_t       ex_size;
   logic [31:2]     ex_pc;

   // MEM/WB
   reg_addr_t       wb_rd;
   logic            wb_we;
   logic [xlen-1:0] wb_data;

   fetch_stage #(
      .reset_pc(reset_pc)
   ) u_fetch (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .stall_i          (stall),
      .redirect_i       (redirect),
      .redirect_target_i(redirect_target),
      .instr_addr_o     (instr_addr_o),
      .instr_data_i     (instr_data_i),
      .instr_o          (if_instr),
      .pc_o             (if_pc),
      .valid_o          (if_valid)
   );

   decode_stage u_decode (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .instr_i      (if_instr),
      .pc_i         (if_pc),
      .valid_i      (if_valid),
      .flush_i      (redirect),
      .ex_rd_i      (id_rd),   // instruction now in execute
      .ex_is_load_i (id_load),
      .rs1_addr_o   (rs1_addr),
      .rs2_addr_o   (rs2_addr),
      .rs1_data_i   (rs1_data),
      .rs2_data_i   (rs2_data),
      .stall_o      (stall),
      .rs1_val_o    (id_rs1_val),
      .rs2_val_o    (id_rs2_val),
      .imm_o        (id_imm),
      .rs1_o        (id_rs1),
      .rs2_o        (id_rs2),
      .alu_op_o     (id_alu_op),
      .alu_src_imm_o(id_src_imm),
      .wb_sel_o     (id_wb_sel),
      .mem_size_o   (id_size),
      .load_o       (id_load),
      .store_o      (id_store),
      .branch_o     (id_branch),
      .branch_ne_o  (id_bne),
      .jump_o       (id_jump),
      .pc_o         (id_pc),
      .rd_o         (id_rd)
   );

   register_file u_regs (
      .clk_i     (clk_i),
      .rs1_addr_i(rs1_addr),
      .rs2_addr_i(rs2_addr),
      .rs1_data_o(rs1_data),
      .rs2_data_o(rs2_data),
      .we_i      (wb_we),
      .rd_i      (wb_rd),
      .wd_i      (wb_data)
   );

   execute_stage u_execute (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .rs1_val_i        (id_rs1_val),
      .rs2_val_i        (id_rs2_val),
      .imm_i            (id_imm),
      .rs1_i            (id_rs1),
      .rs2_i            (id_rs2),
      .alu_op_i         (id_alu_op),
      .alu_src_imm_i    (id_src_imm),
      .wb_sel_i         (id_wb_sel),
      .mem_size_i       (id_size),
      .load_i           (id_load),
      .store_i          (id_store),
      .branch_i         (id_branch),
      .branch_ne_i      (id_bne),
      .jump_i           (id_jump),
      .pc_i             (id_pc),
      .rd_i             (id_rd),
      .mem_rd_i         (wb_rd),
      .mem_we_i         (wb_we),
      .mem_wd_i         (wb_data),
      .redirect_o       (redirect),
      .redirect_target_o(redirect_target),
      .alu_result_o     (ex_alu_result),
      .store_data_o     (ex_store_data),
      .rd_o             (ex_rd),
      .we_o             (ex_we),
      .wb_sel_o         (ex_wb_sel),
      .mem_size_o       (ex_size),
      .load_o           (ex_load),
      .store_o          (ex_store),
      .pc_o             (ex_pc)
   );

   memory_stage u_memory (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .alu_result_i(ex_alu_result),
      .store_data_i(ex_store_data),
      .rd_i        (ex_rd),
      .we_i        (ex_we),
      .wb_sel_i    (ex_wb_sel),
      .mem_size_i  (ex_size),
      .load_i      (ex_load),
      .store_i     (ex_store),
      .pc_i        (ex_pc),
      .data_addr_o (data_addr_o),
      .data_wdata_o(data_wdata_o),
      .data_be_o   (data_be_o),
      .data_we_o   (data_we_o),
      .data_re_o   (data_re_o),
      .data_rdata_i(data_rdata_i),
      .wb_rd_o     (wb_rd),
      .wb_we_o     (wb_we),
      .wb_data_o   (wb_data)
   );

endmodule

/* core_assert.sv */
module core_assert #(
   parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
   input logic        clk_i,
   input logic        reset_i,
   input logic [31:2] instr_addr_o,
   input logic [3:0]  data_be_o,
   input logic        data_we_o,
   input logic        data_re_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0; // assertion failures so far

   // one access per cycle on the data port
   strobe_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
      !(data_we_o && data_re_o))
      else begin
         fail_count++;
         $error("data_we_o and data_re_o high together");
      end

   store_has_lanes: assert property (@(posedge clk_i) disable iff (reset_i)
      data_we_o |-> data_be_o != 4'b0000)
      else begin
         fail_count++;
         $error("store with no byte enabled");
      end

   // first cycle out of reset
   strobes_low_after_reset: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !data_we_o && !data_re_o)
      else begin
         fail_count++;
         $error("data strobe active right after reset");
      end

   fetch_starts_at_reset_pc: assert property (@(posedge clk_i)
      $fell(reset_i) |-> instr_addr_o == reset_pc[31:2])
      else begin
         fail_count++;
         $error("first fetch address differs from reset_pc");
      end

endmodule

/* core_tb.sv */
module core_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;

   localparam logic [xlen-1:0] start_pc = 32'h0000_0040; // program starts at word 16
   localparam int prog_len       = 200;
   localparam int body_end       = prog_len - 16; // register dump starts here
   localparam int result_base    = 256;           // byte address of the dump area
   localparam int timeout_cycles = prog_len * 3 + 50;

   logic            clk_i;
   logic            reset_i;
   logic [31:2]     instr_addr_o;
   logic [31:0]     instr_data_i;
   logic [31:2]     data_addr_o;
   logic [xlen-1:0] data_wdata_o;
   logic [3:0]      data_be_o;
   logic            data_we_o;
   logic            data_re_o;
   logic [xlen-1:0] data_rdata_i;

   logic [31:0]     imem [256];
   logic [xlen-1:0] dmem [128];
   logic [xlen-1:0] m_regs [32]; // reference model state
   logic [xlen-1:0] m_mem [128];
   logic [31:0]     rng_state;

   logic [31:2]     exp_st_addr [$];
   logic [3:0]      exp_st_be [$];
   logic [xlen-1:0] exp_st_data [$];
   logic [31:2]     exp_ld_addr [$];
   logic [xlen-1:0] exp_ld_data [$];
   int              st_idx, ld_idx, cycle_count;

   core #(.reset_pc(start_pc)) uut (.*);

   bind core core_assert #(.reset_pc(reset_pc)) u_core_assert (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   // both memories answer in the same cycle
   assign instr_data_i = $isunknown(instr_addr_o) ? '0 : imem[instr_addr_o[9:2]];
   assign data_rdata_i = $isunknown(data_addr_o)  ? '0 : dmem[data_addr_o[8:2]];

   always @(posedge clk_i) begin
      if (!reset_i && data_we_o) begin
         for (int l = 0; l < 4; l++) begin
            if (data_be_o[l]) dmem[data_addr_o[8:2]][8*l +: 8] <= data_wdata_o[8*l +: 8];
         end
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [xlen-1:0] fill_word(input int w);
      return (w * 32'h9e37_79b9) ^ 32'h6b43_a9b5;
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] f3,
                                         input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, op_reg};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                         input logic [2:0] f3, input reg_addr_t rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input reg_addr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
   endfunction

   task automatic gen_program();
      int          i, skip, base;
      logic [31:0] r, s;
      reg_addr_t   rd, rs1, rs2, prev_rd;
      logic [11:0] imm;
      rng_state = 32'h4de0_83e1;
      base      = int'(start_pc[9:2]);
      for (i = 0; i < 256; i++) begin
         imem[i] = 32'h0; // opcode zero decodes as a bubble
      end
      for (i = 1; i < 16; i++) begin
         rng_state = xorshift(rng_state);
         imem[i-1] = enc_i(rng_state[11:0], 5'd0, 3'b000, reg_addr_t'(i), op_imm);
      end
      prev_rd = 5'd1;
      for (i = 15; i < body_end; i++) begin
         rng_state = xorshift(rng_state);
         r         = rng_state;
         rng_state = xorshift(rng_state);
         s         = rng_state;
         rd  = reg_addr_t'(1 + r[3:0] % 15);
         rs1 = r[12] ? prev_rd : reg_addr_t'(1 + r[7:4] % 15); // bias toward chains
         rs2 = r[13] ? prev_rd : reg_addr_t'(1 + r[11:8] % 15);
         imm = s[11:0];
         case (r[31:27] % 20)
            0:  imem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
            1:  imem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd); // sub
            2:  imem[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3:  imem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
            4:  imem[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
            5:  imem[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd); // slt
            6:  imem[i] = enc_i(imm, rs1, 3'b000, rd, op_imm);
            7:  imem[i] = enc_i(imm, rs1, 3'b111, rd, op_imm);
            8:  imem[i] = enc_i(imm, rs1, 3'b110, rd, op_imm);
            9:  imem[i] = enc_i(imm, rs1, 3'b100, rd, op_imm);
            10: imem[i] = {s[31:12], rd, op_lui};
            11: imem[i] = enc_i({4'b0, s[7:2], 2'b00}, 5'd0, 3'b010, rd, op_load); // lw
            12: imem[i] = enc_i({4'b0, s[7:0]}, 5'd0, 3'b100, rd, op_load);        // lbu
            13: imem[i] = enc_s({4'b0, s[7:2], 2'b00}, rs2, 5'd0, 3'b010);         // sw
            14: imem[i] = enc_s({4'b0, s[7:0]}, rs2, 5'd0, 3'b000);                // sb
            default: begin
               skip = s[1:0] + 1;
               if (i + 1 + skip > body_end) skip = body_end - i - 1; // stay before the dump
               if (s[3:2] == 2'b11) begin
                  imem[i] = enc_j(21'((skip + 1) * 4), rd);
               end else begin
                  imem[i] = enc_b(13'((skip + 1) * 4), rs2, rs1, {2'b00, s[2]});
               end
            end
         endcase
         prev_rd = rd;
      end
      for (i = 1; i < 16; i++) begin
         imem[body_end + i - 1] = enc_s(12'(result_base + 4 * (i - 1)), reg_addr_t'(i),
                                        5'd0, 3'b010);
      end
      imem[prog_len - 1] = enc_j(21'd0, 5'd0); // spins on itself
      // move the program up to the reset address, offsets are relative
      for (i = prog_len - 1; i >= 0; i--) begin
         imem[base + i] = imem[i];
      end
      for (i = 0; i < base; i++) begin
         imem[i] = 32'h0;
      end
   endtask

   // sequential ISA model, records every data access in program order
   task automatic run_model();
      int          pc, nxt;
      logic [31:0] ins, a, b, res, addr, word;
      logic [31:0] imm_i, imm_s, imm_b, imm_j;
      logic [2:0]  f3;
      logic        wr;
      for (pc = 0; pc < 32; pc++) m_regs[pc] = '0;
      for (pc = 0; pc < 128; pc++) m_mem[pc] = fill_word(pc);
      pc = int'(start_pc[9:2]);
      while (pc != int'(start_pc[9:2]) + prog_len - 1) begin
         ins   = imem[pc];
         f3    = ins[14:12];
         a     = m_regs[ins[19:15]];
         b     = m_regs[ins[24:20]];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         res   = '0;
         wr    = 1'b0;
         nxt   = pc + 1;
         case (ins[6:0])
            op_lui: begin
               res = {ins[31:12], 12'h000};
               wr  = 1'b1;
            end
            op_jal: begin
               res = (pc + 1) * 4; // link
               wr  = 1'b1;
               nxt = pc + int'($signed(imm_j) >>> 2);
            end
            op_branch: begin
               if ((a == b) != f3[0]) nxt = pc + int'($signed(imm_b) >>> 2);
            end
            op_load: begin
               addr = a + imm_i;
               word = m_mem[addr[8:2]];
               exp_ld_addr.push_back(addr[31:2]);
               exp_ld_data.push_back(word);
               res = f3[2] ? ((word >> (8 * addr[1:0])) & 32'hff) : word;
               wr  = 1'b1;
            end
            op_store: begin
               addr = a + imm_s;
               exp_st_addr.push_back(addr[31:2]);
               if (f3[1]) begin
                  m_mem[addr[8:2]] = b;
                  exp_st_be.push_back(4'b1111);
                  exp_st_data.push_back(b);
               end else begin
                  m_mem[addr[8:2]][8*addr[1:0] +: 8] = b[7:0];
                  exp_st_be.push_back(4'b0001 << addr[1:0]);
                  exp_st_data.push_back({4{b[7:0]}});
               end
            end
            op_imm: begin
               wr = 1'b1;
               case (f3)
                  3'b100:  res = a ^ imm_i;
                  3'b110:  res = a | imm_i;
                  3'b111:  res = a & imm_i;
                  default: res = a + imm_i;
               endcase
            end
            op_reg: begin
               wr = 1'b1;
               case (f3)
                  3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: res = ins[30] ? a - b : a + b;
               endcase
            end
            default: ;
         endcase
         if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
         pc = nxt;
      end
   endtask

   task automatic fail_now(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_store(input logic [31:2] addr, input logic [3:0] be,
                              input logic [xlen-1:0] data);
      if (st_idx >= exp_st_addr.size()) begin
         fail_now($sformatf("unexpected store to word %h", addr));
      end else if (addr !== exp_st_addr[st_idx] || be !== exp_st_be[st_idx] ||
                   data !== exp_st_data[st_idx]) begin
         fail_now($sformatf("store %0d got %h/%b/%h, expected %h/%b/%h", st_idx, addr, be,
                            data, exp_st_addr[st_idx], exp_st_be[st_idx],
                            exp_st_data[st_idx]));
      end
      st_idx++;
   endtask

   task automatic check_load_data(input logic [31:2] addr, input logic [xlen-1:0] data);
      if (ld_idx >= exp_ld_addr.size()) begin
         fail_now($sformatf("unexpected load from word %h", addr));
      end else if (addr !== exp_ld_addr[ld_idx] || data !== exp_ld_data[ld_idx]) begin
         fail_now($sformatf("load %0d got word %h data %h, expected word %h data %h", ld_idx,
                            addr, data, exp_ld_addr[ld_idx], exp_ld_data[ld_idx]));
      end
      ld_idx++;
   endtask

   // port values are settled by the falling edge
   always @(negedge clk_i) begin
      if (!reset_i) begin
         if (data_we_o) check_store(data_addr_o, data_be_o, data_wdata_o);
         if (data_re_o) check_load_data(data_addr_o, data_rdata_i);
         if (uut.u_core_assert.fail_count != 0) fail_now("a bound assertion failed");
      end
   end

   always @(posedge clk_i) begin
      if (reset_i) begin
         cycle_count <= 0;
      end else begin
         cycle_count <= cycle_count + 1;
         if (cycle_count == timeout_cycles) begin
            $display("Timeout: the program never finished within %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      reset_i     = 1'b1;
      st_idx      = 0;
      ld_idx      = 0;
      gen_program();
      run_model();
      for (int w = 0; w < 128; w++) begin
         dmem[w] = fill_word(w);
      end
      repeat (4) @(posedge clk_i);
      #1 reset_i = 1'b0;
      wait (st_idx == exp_st_addr.size());
      @(negedge clk_i); // one more cycle through the assertions
      if (ld_idx != exp_ld_addr.size()) begin
         fail_now($sformatf("only %0d of %0d expected loads were seen", ld_idx,
                            exp_ld_addr.size()));
      end else if (uut.u_core_assert.fail_count != 0) begin
         fail_now("a bound assertion failed");
      end else begin
         $display("All tests passed");
      end
      $finish;
   end

endmodule

/* files.f */
core_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
core.sv
core_assert.sv
core_tb.sv
